/* bench/branch_subsys_sva.sv */
// Concurrent checks on the branch slice top-level ports, attached to the DUT by a bind in the testbench
`timescale 1ns/1ps
`default_nettype none

module branch_subsys_sva (
    input logic clk_i,
    input logic reset_i,
    input logic inst_valid_i,
    input logic done_o,
    input logic taken_o,
    input logic err_o,
    input logic rd_we_o
);

    // Status flags only together with done
    a_status_with_done: assert property (@(posedge clk_i) disable iff (reset_i)
        (taken_o || err_o) |-> done_o)
        else $error("taken_o or err_o high without done_o");

    a_link_clean: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_we_o |-> (done_o && !err_o))   // Link only on a clean commit
        else $error("rd_we_o high without a clean commit");

    // Fixed latency, strobe to done
    a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_valid_i |-> ##2 done_o)
        else $error("done_o missing two cycles after the issue strobe");

    a_reset_quiet: assert property (@(posedge clk_i) reset_i |=> !done_o)
        else $error("done_o high during reset");

endmodule

`default_nettype wire

/* bench/branch_subsys_tb.sv */
// Testbench for the branch slice that preloads registers, issues branches and jumps and checks each commit
`timescale 1ns/1ps
`default_nettype none

module branch_subsys_tb;

    localparam int          XLEN        = 32;
    localparam logic [31:0] RESET_PC    = 32'h0000_0100;
    localparam int          N_BR        = 8;        // Operand pairs per branch code
    localparam int          N_RAND      = 40;       // Back-to-back mix length
    localparam int          N_INSTR     = 6 * N_BR + N_RAND + 16;
    localparam int          WDOG_CYCLES = N_INSTR * 4 + 16 + 2 * 31 + 200;

    typedef struct packed {
        logic [31:0] pc;
        logic        taken;
        logic        err;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] cyc;       // Issue cycle
    } result_t;

    logic                clk_i = 1'b0;
    logic                reset_i;
    logic                inst_valid_i;
    secv_pkg::inst_t     inst_i;
    logic                reg_we_i;
    secv_pkg::reg_addr_t reg_addr_i;
    logic [31:0]         reg_data_i;
    logic [31:0]         pc_o;
    logic                done_o;
    logic                taken_o;
    logic                err_o;
    logic                rd_we_o;
    secv_pkg::reg_addr_t rd_addr_o;
    logic [31:0]         rd_data_o;

    logic [31:0] mreg [32];     // Model registers
    logic [31:0] mpc;           // Model PC
    result_t     exp_q [$];     // Expected results in issue order
    logic [31:0] cyc = '0;
    int          n_ok = 0;
    int          chk_err = 0;   // Found by the compare process
    int          seq_err = 0;   // Found by the stimulus process

    always #20 clk_i = ~clk_i;
    always @(posedge clk_i) cyc <= cyc + 32'd1;

    branch_subsys #(.XLEN(XLEN), .RESET_PC(RESET_PC)) branch_subsys_inst (
        .clk_i(clk_i), .reset_i(reset_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
        .pc_o(pc_o), .done_o(done_o), .taken_o(taken_o), .err_o(err_o),
        .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o)
    );

    bind branch_subsys branch_subsys_sva branch_subsys_sva_inst (
        .clk_i(clk_i), .reset_i(reset_i), .inst_valid_i(inst_valid_i), .done_o(done_o),
        .taken_o(taken_o), .err_o(err_o), .rd_we_o(rd_we_o)
    );

    // Expected commit from raw instruction bits
    function automatic result_t ref_result(logic [31:0] w, logic [31:0] pc,
                                           logic [31:0] a, logic [31:0] b);
        result_t     r;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        cond;
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        r      = '0;
        cond   = 1'b0;
        r.rd   = w[11:7];
        r.data = pc + 32'd4;
        r.pc   = pc + 32'd4;                        // Fall through by default
        case (w[6:0])
            7'b1100011: begin
                case (w[14:12])
                    3'd0: cond = (a == b);
                    3'd1: cond = (a != b);
                    3'd4: cond = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));   // Signed via bias
                    3'd5: cond = !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
                    3'd6: cond = (a < b);
                    3'd7: cond = !(a < b);
                    default: r.err = 1'b1;
                endcase
                r.taken = cond;
                if (cond) begin
                    r.pc = pc + imm_b;
                end
            end
            7'b1101111: begin                       // JAL
                r.taken = 1'b1;
                r.pc    = pc + imm_j;
                r.we    = (r.rd != 5'd0);
            end
            7'b1100111: begin                       // JALR
                if (w[14:12] == 3'd0) begin
                    r.taken = 1'b1;
                    r.pc    = a + imm_i;
                    r.we    = (r.rd != 5'd0);
                end else begin
                    r.err = 1'b1;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_jalr(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                             logic [11:0] off);
        return {off, rs1, f3, rd, 7'b1100111};
    endfunction

    // Drive one strobe and advance the model right away
    task automatic issue(logic [31:0] w);
        result_t r;
        @(posedge clk_i);
        r     = ref_result(w, mpc, mreg[w[19:15]], mreg[w[24:20]]);
        r.cyc = cyc;
        exp_q.push_back(r);
        mpc = r.pc;
        if (r.we) begin
            mreg[r.rd] = r.data;
        end
        inst_valid_i <= 1'b1;
        inst_i       <= w;
    endtask

    task automatic idle();
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
    endtask

    task automatic preload(logic [4:0] idx, logic [31:0] val);
        @(posedge clk_i);
        reg_we_i   <= 1'b1;
        reg_addr_i <= idx;
        reg_data_i <= val;
        mreg[idx]   = val;
    endtask

    // Let the last results drain, then report the test
    task automatic finish_test(string name, int err_before);
        int waited;
        idle();
        waited = 0;
        while (exp_q.size() != 0 && waited < 4) begin   // Last done lands two edges on
            @(posedge clk_i);
            waited++;
        end
        $display("%-12s finished with %0d errors", name, chk_err + seq_err - err_before);
    endtask

    always @(negedge clk_i) begin : compare
        result_t e;
        int      bad;
        if (!reset_i && done_o) begin
            if (exp_q.size() == 0) begin
                $display("done_o pulsed at %0t with no instruction outstanding", $time);
                chk_err++;
            end else begin
                e   = exp_q.pop_front();
                bad = 0;
                if (pc_o !== e.pc) begin
                    $display("Mismatch at %0t: pc_o %h, expected %h", $time, pc_o, e.pc);
                    bad++;
                end
                if (taken_o !== e.taken || err_o !== e.err) begin
                    $display("Mismatch at %0t: taken/err %b%b, expected %b%b", $time,
                             taken_o, err_o, e.taken, e.err);
                    bad++;
                end
                if (rd_we_o !== e.we) begin
                    $display("Mismatch at %0t: rd_we_o %b, expected %b", $time, rd_we_o, e.we);
                    bad++;
                end
                if (e.we && (rd_addr_o !== e.rd || rd_data_o !== e.data)) begin
                    $display("Mismatch at %0t: link x%0d=%h, expected x%0d=%h", $time,
                             rd_addr_o, rd_data_o, e.rd, e.data);
                    bad++;
                end
                if (cyc - e.cyc != 32'd3) begin     // Drive edge plus two
                    $display("Mismatch at %0t: done_o %0d cycles after issue", $time,
                             cyc - e.cyc - 32'd1);
                    bad++;
                end
                if (bad == 0) begin
                    n_ok++;
                end
                chk_err += bad;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] v;
        logic [31:0] w;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          e0;
        void'($urandom(32'hd0c5));
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        reg_we_i     = 1'b0;
        reg_addr_i   = '0;
        reg_data_i   = '0;
        mpc          = RESET_PC;
        mreg[0]      = '0;
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        e0 = chk_err + seq_err;
        repeat (4) begin
            @(negedge clk_i);
            if (pc_o !== RESET_PC) begin
                $display("Mismatch at %0t: pc_o %h after reset, expected %h", $time, pc_o, RESET_PC);
                seq_err++;
            end
            if (done_o || err_o || rd_we_o) begin
                $display("Mismatch at %0t: status high before any instruction", $time);
                seq_err++;
            end
        end
        for (int i = 1; i < 32; i++) begin
            case (i)
                1:       v = 32'h0000_0001;
                2:       v = 32'hffff_ffff;         // -1 and largest unsigned
                3:       v = 32'h8000_0000;         // Most negative
                4:       v = 32'h7fff_ffff;
                5:       v = 32'h8000_0000;         // Same as x3
                default: v = $urandom();
            endcase
            preload(5'(i), v);
        end
        @(posedge clk_i);
        reg_we_i <= 1'b0;
        finish_test("reset", e0);

        e0 = chk_err + seq_err;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            for (int n = 0; n < N_BR; n++) begin
                rs1 = 5'($urandom_range(8));        // Edge values in x1..x5, random above
                rs2 = (n == 0) ? rs1 : 5'($urandom_range(8));
                issue(enc_branch(3'(f), rs1, rs2, 13'($urandom())));
                idle();
            end
        end
        finish_test("branches", e0);

        e0 = chk_err + seq_err;
        issue(enc_jal(5'd10, 21'd64));
        idle();
        issue(enc_jalr(3'd0, 5'd11, 5'd10, 12'd8)); // Reads the fresh link
        idle();
        issue(enc_jal(5'd12, -21'sd100));
        idle();
        issue(enc_jal(5'd0, 21'd16));
        finish_test("jal", e0);

        e0 = chk_err + seq_err;
        issue(enc_jalr(3'd0, 5'd0, 5'd7, 12'hff4));  // Taken without a link
        idle();
        issue(enc_jalr(3'd0, 5'd13, 5'd2, 12'h7ff));
        idle();
        issue(enc_jalr(3'd0, 5'd14, 5'd9, 12'($urandom())));
        finish_test("jalr", e0);

        e0 = chk_err + seq_err;
        issue(enc_branch(3'd2, 5'd1, 5'd2, 13'd8));
        issue(enc_branch(3'd3, 5'd3, 5'd3, 13'd8));
        issue(enc_jalr(3'd1, 5'd15, 5'd1, 12'd4));
        issue(enc_jalr(3'd5, 5'd16, 5'd4, 12'd4));
        issue({7'd0, 5'd2, 5'd1, 3'd0, 5'd17, 7'b0110011});     // Plain ALU op
        issue({12'd5, 5'd1, 3'd0, 5'd18, 7'b0010011});
        finish_test("errors", e0);

        e0 = chk_err + seq_err;
        for (int n = 0; n < N_RAND; n++) begin
            w = $urandom();
            case ($urandom_range(3))
                0: w[6:0] = 7'b1100011;
                1: w[6:0] = 7'b1101111;
                2: begin
                    w[6:0]   = 7'b1100111;
                    w[14:12] = 3'd0;
                end
                default: w[6:0] = 7'b0110011;
            endcase
            issue(w);
        end
        finish_test("back2back", e0);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            seq_err++;
        end
        $display("Results matched %0d, errors %0d", n_ok, chk_err + seq_err);
        if (chk_err + seq_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WDOG_CYCLES * 40);
        $display("Timeout: run still busy after %0d cycles", WDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/branch.sv */
// Branch function unit resolving target, take decision and link data for branches, JAL and JALR
`timescale 1ns/1ps
`default_nettype none

module branch #(
    parameter int XLEN = secv_pkg::XLEN
) (
    // Control
    input  secv_pkg::inst_t inst_i,     // Instruction under evaluation
    input  logic            ena_i,      // Unit enabled this cycle
    output logic            rdy_o,      // Result valid
    output logic            err_o,      // Illegal funct3
    // Operands
    input  logic [XLEN-1:0] pc_i,       // Current PC
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,      // Already decoded immediate
    // Results
    output logic [XLEN-1:0] pc_o,       // Target address
    output logic            pc_wb_o,    // Take the target
    output logic [XLEN-1:0] rd_o,       // Return address
    output logic            rd_wb_o     // Write the link
);

    secv_pkg::opcode_t opcode;
    secv_pkg::funct3_t funct3;
    logic              take;
    logic              link;
    logic              err;

    assign opcode = inst_i.r_type.opcode;
    assign funct3 = inst_i.r_type.funct3;

    // Target address
    always_comb begin
        if (opcode == secv_pkg::OPCODE_JALR) begin
            pc_o = rs1_i + imm_i;       // Register relative
        end else if (opcode == secv_pkg::OPCODE_BRANCH || opcode == secv_pkg::OPCODE_JAL) begin
            pc_o = pc_i + imm_i;        // PC relative
        end else begin
            pc_o = pc_i;
        end
    end

    assign rd_o = pc_i + XLEN'(4);      // Link value and fall-through

    // Decision and error
    always_comb begin
        take = 1'b0;
        link = 1'b0;
        err  = 1'b0;
        case (opcode)
            secv_pkg::OPCODE_BRANCH: begin
                case (funct3)
                    secv_pkg::FUNCT3_BRANCH_BEQ:  take = (rs1_i == rs2_i);
                    secv_pkg::FUNCT3_BRANCH_BNE:  take = (rs1_i != rs2_i);
                    secv_pkg::FUNCT3_BRANCH_BLT:  take = ($signed(rs1_i) < $signed(rs2_i));
                    secv_pkg::FUNCT3_BRANCH_BGE:  take = ($signed(rs1_i) >= $signed(rs2_i));
                    secv_pkg::FUNCT3_BRANCH_BLTU: take = (rs1_i < rs2_i);
                    secv_pkg::FUNCT3_BRANCH_BGEU: take = (rs1_i >= rs2_i);
                    default:                      err  = 1'b1;   // Codes 2 and 3
                endcase
            end
            secv_pkg::OPCODE_JAL: begin
                take = 1'b1;
                link = 1'b1;
            end
            secv_pkg::OPCODE_JALR: begin
                if (funct3 == 3'b000) begin
                    take = 1'b1;
                    link = 1'b1;
                end else begin
                    err = 1'b1;     // Only funct3 0 defined
                end
            end
            default: ;              // Anything else just falls through
        endcase
    end

    assign rdy_o   = ena_i;
    assign err_o   = err;
    assign pc_wb_o = take;
    assign rd_wb_o = link;

endmodule

`default_nettype wire

/* design/branch_subsys.sv */
// Top level of the branch and jump slice, wiring control, immediate decoder, register file and branch unit
`timescale 1ns/1ps
`default_nettype none

module branch_subsys #(
    parameter int              XLEN     = secv_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  secv_pkg::inst_t     inst_i,
    input  logic                reg_we_i,       // Preload port
    input  secv_pkg::reg_addr_t reg_addr_i,
    input  logic [XLEN-1:0]     reg_data_i,
    output logic [XLEN-1:0]     pc_o,
    output logic                done_o,
    output logic                taken_o,
    output logic                err_o,
    output logic                rd_we_o,
    output secv_pkg::reg_addr_t rd_addr_o,
    output logic [XLEN-1:0]     rd_data_o
);

    secv_pkg::inst_t     ex_inst;
    logic                ex_ena;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic                br_rdy;
    logic                br_err;
    logic [XLEN-1:0]     br_target;
    logic                br_pc_wb;
    logic [XLEN-1:0]     br_ret;
    logic                br_rd_wb;
    logic                rf_we;
    secv_pkg::reg_addr_t rf_waddr;
    logic [XLEN-1:0]     rf_wdata;

    exec_ctrl #(.XLEN(XLEN), .RESET_PC(RESET_PC)) exec_ctrl_inst (
        .clk_i(clk_i), .reset_i(reset_i),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
        .ex_inst_o(ex_inst), .ex_ena_o(ex_ena), .pc_o(pc_o),
        .rdy_i(br_rdy), .err_i(br_err), .target_i(br_target),
        .pc_wb_i(br_pc_wb), .ret_i(br_ret), .rd_wb_i(br_rd_wb),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .done_o(done_o), .taken_o(taken_o), .err_o(err_o),
        .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o)
    );

    imm_decoder #(.XLEN(XLEN)) imm_decoder_inst (
        .inst_i(ex_inst),
        .imm_o(imm)
    );

    // Operand addresses straight from the stage-2 word
    regfile #(.XLEN(XLEN)) regfile_inst (
        .clk_i(clk_i),
        .rs1_addr_i(ex_inst.r_type.rs1), .rs2_addr_i(ex_inst.r_type.rs2),
        .rs1_o(rs1_data), .rs2_o(rs2_data),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    branch #(.XLEN(XLEN)) branch_inst (
        .inst_i(ex_inst), .ena_i(ex_ena), .rdy_o(br_rdy), .err_o(br_err),
        .pc_i(pc_o), .rs1_i(rs1_data), .rs2_i(rs2_data), .imm_i(imm),
        .pc_o(br_target), .pc_wb_o(br_pc_wb), .rd_o(br_ret), .rd_wb_o(br_rd_wb)
    );

endmodule

`default_nettype wire

/* design/exec_ctrl.sv */
// Issue and commit control holding the PC and issue register, arbitrating the register write port
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
    parameter int              XLEN     = secv_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                reset_i,
    // Issue side
    input  logic                inst_valid_i,   // One-cycle strobe
    input  secv_pkg::inst_t     inst_i,
    // Preload port
    input  logic                reg_we_i,
    input  secv_pkg::reg_addr_t reg_addr_i,
    input  logic [XLEN-1:0]     reg_data_i,
    // To datapath
    output secv_pkg::inst_t     ex_inst_o,      // Stage-2 instruction
    output logic                ex_ena_o,
    output logic [XLEN-1:0]     pc_o,
    // From branch unit
    input  logic                rdy_i,
    input  logic                err_i,
    input  logic [XLEN-1:0]     target_i,
    input  logic                pc_wb_i,
    input  logic [XLEN-1:0]     ret_i,
    input  logic                rd_wb_i,
    // Register write port
    output logic                rf_we_o,
    output secv_pkg::reg_addr_t rf_waddr_o,
    output logic [XLEN-1:0]     rf_wdata_o,
    // Commit status
    output logic                done_o,
    output logic                taken_o,
    output logic                err_o,
    output logic                rd_we_o,
    output secv_pkg::reg_addr_t rd_addr_o,
    output logic [XLEN-1:0]     rd_data_o
);

    secv_pkg::inst_t     iss_inst;      // Issue register
    logic                iss_valid;
    secv_pkg::reg_addr_t ex_rd;
    logic                link_we;       // Link commit this cycle

    // Stage 1 capture
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= inst_valid_i;
        end
        iss_inst <= inst_i;     // Payload only
    end

    assign ex_inst_o = iss_inst;
    assign ex_ena_o  = iss_valid;
    assign ex_rd     = iss_inst.r_type.rd;

    // No link on error or x0
    assign link_we = rdy_i && rd_wb_i && !err_i && (ex_rd != 5'd0);

    // Link commit has priority over preload
    assign rf_we_o    = link_we || reg_we_i;
    assign rf_waddr_o = link_we ? ex_rd : reg_addr_i;
    assign rf_wdata_o = link_we ? ret_i : reg_data_i;

    // PC and status commit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o    <= RESET_PC;
            done_o  <= 1'b0;
            taken_o <= 1'b0;
            err_o   <= 1'b0;
            rd_we_o <= 1'b0;
        end else begin
            if (rdy_i) begin
                pc_o <= pc_wb_i ? target_i : ret_i;   // Target or PC+4
            end
            done_o  <= rdy_i;
            taken_o <= rdy_i && pc_wb_i;
            err_o   <= rdy_i && err_i;
            rd_we_o <= link_we;
        end
        rd_addr_o <= ex_rd;     // Meaningful with rd_we_o
        rd_data_o <= ret_i;
    end

endmodule

`default_nettype wire

/* design/imm_decoder.sv */
// Immediate decoder that turns the I-, B- or J-type fields into a sign-extended operand for the branch unit
`timescale 1ns/1ps
`default_nettype none

module imm_decoder #(
    parameter int XLEN = secv_pkg::XLEN
) (
    input  secv_pkg::inst_t   inst_i,   // Instruction in stage 2
    output logic [XLEN-1:0]   imm_o     // Sign-extended immediate
);

    logic [11:0] i_imm;     // JALR offset
    logic [12:0] b_imm;     // Branch offset, bit 0 always zero
    logic [20:0] j_imm;     // JAL offset, bit 0 always zero

    // Reassemble the scattered fields
    assign i_imm = inst_i.i_type.imm;
    assign b_imm = {inst_i.b_type.imm_12, inst_i.b_type.imm_11,
                    inst_i.b_type.imm_10_5, inst_i.b_type.imm_4_1, 1'b0};
    assign j_imm = {inst_i.j_type.imm_20, inst_i.j_type.imm_19_12,
                    inst_i.j_type.imm_11, inst_i.j_type.imm_10_1, 1'b0};

    // Pick format by opcode
    always_comb begin
        case (inst_i.r_type.opcode)
            secv_pkg::OPCODE_JALR:   imm_o = {{(XLEN-12){i_imm[11]}}, i_imm};
            secv_pkg::OPCODE_BRANCH: imm_o = {{(XLEN-13){b_imm[12]}}, b_imm};
            secv_pkg::OPCODE_JAL:    imm_o = {{(XLEN-21){j_imm[20]}}, j_imm};
            default:                 imm_o = '0;   // Not a control transfer
        endcase
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
// Integer register file with two combinational read ports and one clocked write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int XLEN = secv_pkg::XLEN
) (
    input  logic                clk_i,
    // Read side, driven from the stage-2 instruction
    input  secv_pkg::reg_addr_t rs1_addr_i,
    input  secv_pkg::reg_addr_t rs2_addr_i,
    output logic [XLEN-1:0]     rs1_o,
    output logic [XLEN-1:0]     rs2_o,
    // Single write port, already arbitrated upstream
    input  logic                we_i,
    input  secv_pkg::reg_addr_t waddr_i,
    input  logic [XLEN-1:0]     wdata_i
);

    logic [XLEN-1:0] regs [32];     // Register storage, no reset

    // Write on the edge
    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != 5'd0)) begin   // x0 writes dropped
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads
    always_comb begin
        if (rs1_addr_i == 5'd0) begin
            rs1_o = '0;
        end else begin
            rs1_o = regs[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == 5'd0) begin
            rs2_o = '0;
        end else begin
            rs2_o = regs[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

/* design/secv_pkg.sv */
// Shared SEC-V types and constants for the branch slice, referenced by scoped name in every RTL block
`default_nettype none

package secv_pkg;

    // Default data and address width
    parameter int XLEN = 32;

    // Basic field types
    typedef logic [6:0] opcode_t;   // Major opcode
    typedef logic [2:0] funct3_t;   // Minor function code
    typedef logic [4:0] reg_addr_t; // Register index x0..x31

    // Major opcodes handled by the branch unit
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;

    // Conditional branch codes, 3'b010 and 3'b011 are illegal
    localparam funct3_t FUNCT3_BRANCH_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BRANCH_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BRANCH_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BRANCH_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BRANCH_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BRANCH_BGEU = 3'b111;

    // One 32-bit instruction word seen through its encoding formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            funct3_t    funct3;
            reg_addr_t  rd;
            opcode_t    opcode;
        } r_type;
        struct packed {
            logic [11:0] imm;       // imm[11:0]
            reg_addr_t   rs1;
            funct3_t     funct3;
            reg_addr_t   rd;
            opcode_t     opcode;
        } i_type;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            funct3_t    funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;     // Sits in the rd slot
            opcode_t    opcode;
        } b_type;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_addr_t  rd;
            opcode_t    opcode;
        } j_type;
    } inst_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the branch slice testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module branch_subsys_tb -o branch_subsys_sim
out=$(./obj_dir/branch_subsys_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* tb.f */
design/secv_pkg.sv
design/imm_decoder.sv
design/regfile.sv
design/branch.sv
design/exec_ctrl.sv
design/branch_subsys.sv
bench/branch_subsys_sva.sv
bench/branch_subsys_tb.sv
